// File: logic/thumb_ctrl_pkg.sv
`default_nettype none

package thumb_ctrl_pkg;

    typedef logic [15:0] instr_t;
    typedef logic [31:0] word_t;
    typedef logic [3:0]  reg_addr_t;
    typedef logic [15:0] reg_list_t;
    typedef logic [4:0]  beat_t;

    localparam reg_addr_t SP_REG        = 4'd13;
    localparam int        LR_BIT        = 14;
    localparam int        PC_BIT        = 15;
    localparam word_t     BYTES_PER_REG = 32'd4;

    // top five opcode bits, matched with casez
    localparam logic [4:0] OP_SHIFT_IMM = 5'b00???;
    localparam logic [4:0] OP_DATA_PROC = 5'b01000;
    localparam logic [4:0] OP_LS_REG    = 5'b0101?;
    localparam logic [4:0] OP_LS_IMM    = 5'b011??;
    localparam logic [4:0] OP_LS_HALF   = 5'b1000?;
    localparam logic [4:0] OP_LS_SP     = 5'b1001?;
    localparam logic [4:0] OP_MISC      = 5'b1011?;
    localparam logic [4:0] OP_STM       = 5'b11000;
    localparam logic [4:0] OP_LDM       = 5'b11001;

    // misc group, bits 11:9
    localparam logic [2:0] MISC_PUSH = 3'b010;
    localparam logic [2:0] MISC_POP  = 3'b110;

    // shift/add/sub/mov/cmp group, bits 13:9
    localparam logic [4:0] LSL_IMM  = 5'b000??;
    localparam logic [4:0] LSR_IMM  = 5'b001??;
    localparam logic [4:0] ASR_IMM  = 5'b010??;
    localparam logic [4:0] ADD_REG  = 5'b01100;
    localparam logic [4:0] SUB_REG  = 5'b01101;
    localparam logic [4:0] ADD_IMM3 = 5'b01110;
    localparam logic [4:0] SUB_IMM3 = 5'b01111;
    localparam logic [4:0] MOV_IMM8 = 5'b100??;
    localparam logic [4:0] CMP_IMM8 = 5'b101??;
    localparam logic [4:0] ADD_IMM8 = 5'b110??;
    localparam logic [4:0] SUB_IMM8 = 5'b111??;

    // data-processing group, bits 9:6
    localparam logic [3:0] DP_AND = 4'h0;
    localparam logic [3:0] DP_EOR = 4'h1;
    localparam logic [3:0] DP_LSL = 4'h2;
    localparam logic [3:0] DP_LSR = 4'h3;
    localparam logic [3:0] DP_ASR = 4'h4;
    localparam logic [3:0] DP_ADC = 4'h5;
    localparam logic [3:0] DP_SBC = 4'h6;
    localparam logic [3:0] DP_ROR = 4'h7;
    localparam logic [3:0] DP_TST = 4'h8;
    localparam logic [3:0] DP_RSB = 4'h9;
    localparam logic [3:0] DP_CMP = 4'hA;
    localparam logic [3:0] DP_CMN = 4'hB;
    localparam logic [3:0] DP_ORR = 4'hC;
    localparam logic [3:0] DP_MUL = 4'hD;
    localparam logic [3:0] DP_BIC = 4'hE;
    localparam logic [3:0] DP_MVN = 4'hF;

    typedef enum logic [3:0] {
        ALU_ADD, ALU_SUB, ALU_AND, ALU_OR, ALU_XOR, ALU_NOT,
        ALU_BIT_CLEAR, ALU_MULT, ALU_LSL, ALU_LSR, ALU_ASR, ALU_ROR
    } alu_op_e;

    typedef enum logic [1:0] {SRC_REG, SRC_IMM, SRC_ZERO, SRC_OFFSET} operand_src_e;
    typedef enum logic {WB_ALU, WB_MEM} wb_src_e;
    typedef enum logic {ADDR_INSTR, ADDR_CTRL} addr_src_e;
    typedef enum logic [2:0] {BLK_NONE, BLK_PUSH, BLK_POP, BLK_STM, BLK_LDM} block_kind_e;

    typedef struct packed {
        logic         valid;
        logic         mem_write;
        logic         mem_read;
        logic         reg_write;
        wb_src_e      wb_src;
        operand_src_e alu_a_src;
        operand_src_e alu_b_src;
        alu_op_e      alu_op;
        addr_src_e    reg_addr2_src;
        addr_src_e    dest_addr_src;
        reg_addr_t    reg_addr;
        word_t        offset_imm;
    } ctrl_t;

    typedef struct packed {
        block_kind_e kind;
        reg_list_t   list;
        reg_addr_t   base;
    } block_req_t;

endpackage

`default_nettype wire

// File: logic/reglist_scan.sv
`timescale 1ns/1ps
`default_nettype none

module reglist_scan (
    input  thumb_ctrl_pkg::reg_list_t  list_i,
    input  thumb_ctrl_pkg::reg_list_t  pending_i,
    input  wire logic                  descending_i,
    output thumb_ctrl_pkg::reg_addr_t  next_reg_o,
    output thumb_ctrl_pkg::reg_list_t  next_onehot_o,
    output logic                       more_o,
    output thumb_ctrl_pkg::beat_t      count_o
);

    thumb_ctrl_pkg::reg_list_t masked;
    thumb_ctrl_pkg::reg_addr_t lowest;
    thumb_ctrl_pkg::reg_addr_t highest;

    assign masked = list_i & pending_i;
    assign more_o = |masked;

    always_comb begin
        lowest  = '0;
        highest = '0;
        count_o = '0;
        // later hits win, so scan each way once
        for (int i = 15; i >= 0; i--) begin
            if (masked[i]) begin
                lowest = thumb_ctrl_pkg::reg_addr_t'(i);
            end
        end
        for (int i = 0; i < 16; i++) begin
            if (masked[i]) begin
                highest = thumb_ctrl_pkg::reg_addr_t'(i);
            end
            count_o = count_o + thumb_ctrl_pkg::beat_t'(list_i[i]);
        end
    end

    assign next_reg_o    = descending_i ? highest : lowest;
    assign next_onehot_o = more_o ? (16'd1 << next_reg_o) : '0;

endmodule

`default_nettype wire

// File: logic/op_decoder.sv
`timescale 1ns/1ps
`default_nettype none

module op_decoder (
    input  thumb_ctrl_pkg::instr_t     instr_i,
    output thumb_ctrl_pkg::ctrl_t      base_ctrl_o,
    output thumb_ctrl_pkg::block_req_t block_req_o
);

    logic [4:0] top_op;
    logic       reg_form_load;

    assign top_op = instr_i[15:11];
    // register form loads also show up as bits 10:9 both set
    assign reg_form_load = instr_i[11] || (instr_i[10:9] == 2'b11);

    always_comb begin
        base_ctrl_o.valid         = 1'b1;
        base_ctrl_o.mem_write     = 1'b0;
        base_ctrl_o.mem_read      = 1'b0;
        base_ctrl_o.reg_write     = 1'b0;
        base_ctrl_o.wb_src        = thumb_ctrl_pkg::WB_ALU;
        base_ctrl_o.alu_a_src     = thumb_ctrl_pkg::SRC_REG;
        base_ctrl_o.alu_b_src     = thumb_ctrl_pkg::SRC_REG;
        base_ctrl_o.alu_op        = thumb_ctrl_pkg::ALU_ADD;
        base_ctrl_o.reg_addr2_src = thumb_ctrl_pkg::ADDR_INSTR;
        base_ctrl_o.dest_addr_src = thumb_ctrl_pkg::ADDR_INSTR;
        base_ctrl_o.reg_addr      = '0;
        base_ctrl_o.offset_imm    = '0;
        block_req_o.kind          = thumb_ctrl_pkg::BLK_NONE;
        block_req_o.list          = '0;
        block_req_o.base          = '0;

        casez (top_op)
            thumb_ctrl_pkg::OP_SHIFT_IMM: begin
                base_ctrl_o.reg_write = 1'b1;
                base_ctrl_o.alu_b_src = thumb_ctrl_pkg::SRC_IMM;
                casez (instr_i[13:9])
                    thumb_ctrl_pkg::LSL_IMM: base_ctrl_o.alu_op = thumb_ctrl_pkg::ALU_LSL;
                    thumb_ctrl_pkg::LSR_IMM: base_ctrl_o.alu_op = thumb_ctrl_pkg::ALU_LSR;
                    thumb_ctrl_pkg::ASR_IMM: base_ctrl_o.alu_op = thumb_ctrl_pkg::ALU_ASR;
                    thumb_ctrl_pkg::ADD_REG: base_ctrl_o.alu_b_src = thumb_ctrl_pkg::SRC_REG;
                    thumb_ctrl_pkg::SUB_REG: begin
                        base_ctrl_o.alu_op    = thumb_ctrl_pkg::ALU_SUB;
                        base_ctrl_o.alu_b_src = thumb_ctrl_pkg::SRC_REG;
                    end
                    thumb_ctrl_pkg::ADD_IMM3, thumb_ctrl_pkg::ADD_IMM8: ;
                    thumb_ctrl_pkg::SUB_IMM3, thumb_ctrl_pkg::SUB_IMM8: begin
                        base_ctrl_o.alu_op = thumb_ctrl_pkg::ALU_SUB;
                    end
                    thumb_ctrl_pkg::MOV_IMM8: base_ctrl_o.alu_a_src = thumb_ctrl_pkg::SRC_ZERO;
                    thumb_ctrl_pkg::CMP_IMM8: begin
                        base_ctrl_o.alu_op    = thumb_ctrl_pkg::ALU_SUB;
                        base_ctrl_o.reg_write = 1'b0;
                    end
                    default: ;
                endcase
            end
            thumb_ctrl_pkg::OP_DATA_PROC: begin
                // bit 10 set is the special-register group, not kept
                base_ctrl_o.valid     = !instr_i[10];
                base_ctrl_o.reg_write = !instr_i[10];
                case (instr_i[9:6])
                    thumb_ctrl_pkg::DP_AND: base_ctrl_o.alu_op = thumb_ctrl_pkg::ALU_AND;
                    thumb_ctrl_pkg::DP_EOR: base_ctrl_o.alu_op = thumb_ctrl_pkg::ALU_XOR;
                    thumb_ctrl_pkg::DP_LSL: base_ctrl_o.alu_op = thumb_ctrl_pkg::ALU_LSL;
                    thumb_ctrl_pkg::DP_LSR: base_ctrl_o.alu_op = thumb_ctrl_pkg::ALU_LSR;
                    thumb_ctrl_pkg::DP_ASR: base_ctrl_o.alu_op = thumb_ctrl_pkg::ALU_ASR;
                    thumb_ctrl_pkg::DP_ADC: base_ctrl_o.alu_op = thumb_ctrl_pkg::ALU_ADD;
                    thumb_ctrl_pkg::DP_SBC: base_ctrl_o.alu_op = thumb_ctrl_pkg::ALU_SUB;
                    thumb_ctrl_pkg::DP_ROR: base_ctrl_o.alu_op = thumb_ctrl_pkg::ALU_ROR;
                    thumb_ctrl_pkg::DP_TST: begin
                        base_ctrl_o.alu_op    = thumb_ctrl_pkg::ALU_AND;
                        base_ctrl_o.reg_write = 1'b0;
                    end
                    thumb_ctrl_pkg::DP_RSB: begin
                        base_ctrl_o.alu_op    = thumb_ctrl_pkg::ALU_SUB;
                        base_ctrl_o.alu_a_src = thumb_ctrl_pkg::SRC_ZERO;
                    end
                    thumb_ctrl_pkg::DP_CMP: begin
                        base_ctrl_o.alu_op    = thumb_ctrl_pkg::ALU_SUB;
                        base_ctrl_o.reg_write = 1'b0;
                    end
                    thumb_ctrl_pkg::DP_CMN: base_ctrl_o.reg_write = 1'b0;
                    thumb_ctrl_pkg::DP_ORR: base_ctrl_o.alu_op = thumb_ctrl_pkg::ALU_OR;
                    thumb_ctrl_pkg::DP_MUL: base_ctrl_o.alu_op = thumb_ctrl_pkg::ALU_MULT;
                    thumb_ctrl_pkg::DP_BIC: base_ctrl_o.alu_op = thumb_ctrl_pkg::ALU_BIT_CLEAR;
                    thumb_ctrl_pkg::DP_MVN: base_ctrl_o.alu_op = thumb_ctrl_pkg::ALU_NOT;
                endcase
            end
            thumb_ctrl_pkg::OP_LS_REG: begin
                base_ctrl_o.wb_src    = thumb_ctrl_pkg::WB_MEM;
                base_ctrl_o.reg_write = reg_form_load;
                base_ctrl_o.mem_read  = reg_form_load;
                base_ctrl_o.mem_write = !reg_form_load;
            end
            thumb_ctrl_pkg::OP_LS_IMM, thumb_ctrl_pkg::OP_LS_HALF,
            thumb_ctrl_pkg::OP_LS_SP: begin
                base_ctrl_o.alu_b_src = thumb_ctrl_pkg::SRC_IMM;
                base_ctrl_o.wb_src    = thumb_ctrl_pkg::WB_MEM;
                base_ctrl_o.reg_write = instr_i[11];
                base_ctrl_o.mem_read  = instr_i[11];
                base_ctrl_o.mem_write = !instr_i[11];
            end
            thumb_ctrl_pkg::OP_MISC: begin
                // LR sits at bit 14 for push, PC at bit 15 for pop
                if (instr_i[11:9] == thumb_ctrl_pkg::MISC_PUSH) begin
                    block_req_o.kind = thumb_ctrl_pkg::BLK_PUSH;
                    block_req_o.list = {1'b0, instr_i[8], 6'b0, instr_i[7:0]};
                    block_req_o.base = thumb_ctrl_pkg::SP_REG;
                end else if (instr_i[11:9] == thumb_ctrl_pkg::MISC_POP) begin
                    block_req_o.kind = thumb_ctrl_pkg::BLK_POP;
                    block_req_o.list = {instr_i[8], 7'b0, instr_i[7:0]};
                    block_req_o.base = thumb_ctrl_pkg::SP_REG;
                end else begin
                    base_ctrl_o.valid = 1'b0;
                end
            end
            thumb_ctrl_pkg::OP_STM, thumb_ctrl_pkg::OP_LDM: begin
                block_req_o.kind = instr_i[11] ? thumb_ctrl_pkg::BLK_LDM : thumb_ctrl_pkg::BLK_STM;
                block_req_o.list = {8'b0, instr_i[7:0]};
                block_req_o.base = {1'b0, instr_i[10:8]};
            end
            default: base_ctrl_o.valid = 1'b0;
        endcase
    end

endmodule

`default_nettype wire

// File: logic/block_transfer_ctrl.sv
`timescale 1ns/1ps
`default_nettype none

module block_transfer_ctrl (
    input  wire logic                  clk_i,
    input  wire logic                  rst_i,
    input  thumb_ctrl_pkg::ctrl_t      base_ctrl_i,
    input  thumb_ctrl_pkg::block_req_t block_req_i,
    output thumb_ctrl_pkg::ctrl_t      ctrl_o,
    output logic                       stall_o
);

    thumb_ctrl_pkg::reg_list_t pending;
    thumb_ctrl_pkg::beat_t     beat_k;
    logic                      base_loaded;

    thumb_ctrl_pkg::reg_addr_t next_reg;
    thumb_ctrl_pkg::reg_list_t next_onehot;
    thumb_ctrl_pkg::beat_t     list_count;
    logic                      more;
    logic                      descending;
    thumb_ctrl_pkg::word_t     bytes_n;
    thumb_ctrl_pkg::word_t     bytes_k;

    // LDM walks the list from the top down
    assign descending = (block_req_i.kind == thumb_ctrl_pkg::BLK_LDM);

    reglist_scan u_reglist_scan (
        .list_i        (block_req_i.list),
        .pending_i     (pending),
        .descending_i  (descending),
        .next_reg_o    (next_reg),
        .next_onehot_o (next_onehot),
        .more_o        (more),
        .count_o       (list_count)
    );

    assign bytes_n = thumb_ctrl_pkg::word_t'(list_count) * thumb_ctrl_pkg::BYTES_PER_REG;
    assign bytes_k = thumb_ctrl_pkg::word_t'(beat_k) * thumb_ctrl_pkg::BYTES_PER_REG;
    assign stall_o = (block_req_i.kind != thumb_ctrl_pkg::BLK_NONE) && more;

    always_comb begin
        ctrl_o = base_ctrl_i;
        if (block_req_i.kind != thumb_ctrl_pkg::BLK_NONE) begin
            ctrl_o.alu_b_src = thumb_ctrl_pkg::SRC_OFFSET;
            ctrl_o.reg_addr  = next_reg;
        end
        case (block_req_i.kind)
            thumb_ctrl_pkg::BLK_PUSH: begin
                ctrl_o.alu_op = thumb_ctrl_pkg::ALU_SUB;
                if (more) begin
                    ctrl_o.mem_write     = 1'b1;
                    ctrl_o.reg_addr2_src = thumb_ctrl_pkg::ADDR_CTRL;
                    ctrl_o.offset_imm    = bytes_n - bytes_k;
                end else begin
                    ctrl_o.reg_write     = 1'b1;
                    ctrl_o.reg_addr      = thumb_ctrl_pkg::SP_REG;
                    ctrl_o.dest_addr_src = thumb_ctrl_pkg::ADDR_CTRL;
                    ctrl_o.offset_imm    = bytes_n;
                end
            end
            thumb_ctrl_pkg::BLK_POP: begin
                ctrl_o.dest_addr_src = thumb_ctrl_pkg::ADDR_CTRL;
                ctrl_o.offset_imm    = bytes_k;
                if (more) begin
                    ctrl_o.reg_write = 1'b1;
                    ctrl_o.mem_read  = 1'b1;
                    ctrl_o.wb_src    = thumb_ctrl_pkg::WB_MEM;
                end else begin
                    ctrl_o.reg_addr  = thumb_ctrl_pkg::SP_REG;
                    ctrl_o.reg_write = block_req_i.list[thumb_ctrl_pkg::PC_BIT];
                end
            end
            thumb_ctrl_pkg::BLK_STM: begin
                if (more) begin
                    ctrl_o.mem_write     = 1'b1;
                    ctrl_o.reg_addr2_src = thumb_ctrl_pkg::ADDR_CTRL;
                    ctrl_o.offset_imm    = bytes_k;
                end else begin
                    ctrl_o.reg_write     = 1'b1;
                    ctrl_o.reg_addr      = block_req_i.base;
                    ctrl_o.dest_addr_src = thumb_ctrl_pkg::ADDR_CTRL;
                    ctrl_o.offset_imm    = bytes_n;
                end
            end
            thumb_ctrl_pkg::BLK_LDM: begin
                ctrl_o.dest_addr_src = thumb_ctrl_pkg::ADDR_CTRL;
                if (more) begin
                    ctrl_o.reg_write  = 1'b1;
                    ctrl_o.mem_read   = 1'b1;
                    ctrl_o.wb_src     = thumb_ctrl_pkg::WB_MEM;
                    ctrl_o.offset_imm = bytes_n - thumb_ctrl_pkg::BYTES_PER_REG - bytes_k;
                end else begin
                    // a loaded base keeps its loaded value
                    ctrl_o.reg_write  = !base_loaded;
                    ctrl_o.reg_addr   = block_req_i.base;
                    ctrl_o.offset_imm = bytes_n;
                end
            end
            default: ;
        endcase
    end

    always_ff @(posedge clk_i) begin
        if (rst_i || !stall_o) begin
            pending     <= '1;
            beat_k      <= '0;
            base_loaded <= 1'b0;
        end else begin
            pending <= pending & ~next_onehot;
            beat_k  <= beat_k + 5'd1;
            if (descending && (next_reg == block_req_i.base)) begin
                base_loaded <= 1'b1;
            end
        end
    end

    // single-beat instructions only arrive once the walk is idle
    assert property (@(posedge clk_i) disable iff (rst_i)
        (block_req_i.kind == thumb_ctrl_pkg::BLK_NONE) |-> (pending == '1) && (beat_k == '0));

    // the walk ends before the beat count passes the list size
    assert property (@(posedge clk_i) disable iff (rst_i) beat_k <= list_count);

endmodule

`default_nettype wire

// File: logic/thumb_ctrl_top.sv
`timescale 1ns/1ps
`default_nettype none

module thumb_ctrl_top (
    input  wire logic                   clk_i,
    input  wire logic                   rst_i,
    input  thumb_ctrl_pkg::instr_t      instr_i,
    output thumb_ctrl_pkg::ctrl_t       ctrl_o,
    output logic                        stall_o
);

    thumb_ctrl_pkg::ctrl_t      base_ctrl;
    thumb_ctrl_pkg::block_req_t block_req;

    op_decoder u_op_decoder (
        .instr_i     (instr_i),
        .base_ctrl_o (base_ctrl),
        .block_req_o (block_req)
    );

    // sequences the multi-register transfers, passes the rest through
    block_transfer_ctrl u_block_transfer_ctrl (
        .clk_i       (clk_i),
        .rst_i       (rst_i),
        .base_ctrl_i (base_ctrl),
        .block_req_i (block_req),
        .ctrl_o      (ctrl_o),
        .stall_o     (stall_o)
    );

endmodule

`default_nettype wire

// File: tb/tb_thumb_ctrl.sv
`timescale 1ns/1ps
`default_nettype none

module tb_thumb_ctrl;

    localparam int CLK_PERIOD  = 20;
    localparam int STALL_LIMIT = 20;

    // one line of the vector file
    typedef struct packed {
        logic [7:0]  test;
        logic [15:0] instr;
        logic [15:0] dc;
        logic        stall;
        logic        valid;
        logic        reg_write;
        logic        mem_write;
        logic [3:0]  reg_addr;
        logic [31:0] offset;
        logic [3:0]  alu_op;
        logic [1:0]  a_src;
        logic [1:0]  b_src;
        logic        wb_src;
    } vec_t;

    logic                   clk;
    logic                   rst;
    thumb_ctrl_pkg::instr_t instr;
    thumb_ctrl_pkg::ctrl_t  ctrl;
    logic                   stall;

    vec_t        vecs[$];
    logic [31:0] rng_state;
    logic [7:0]  cur_test;
    int          test_errs;
    int          pass_count;
    int          fail_count;
    logic        timed_out;
    logic        load_failed;

    thumb_ctrl_top uut (
        .clk_i   (clk),
        .rst_i   (rst),
        .instr_i (instr),
        .ctrl_o  (ctrl),
        .stall_o (stall)
    );

    always #(CLK_PERIOD / 2) clk = ~clk;

    function automatic logic [31:0] xorshift32(input logic [31:0] x);
        logic [31:0] y;
        y = x ^ (x << 13);
        y = y ^ (y >> 17);
        y = y ^ (y << 5);
        return y;
    endfunction

    task automatic load_vectors();
        int          fd;
        int          fields;
        string       line;
        logic [31:0] f [13];
        vec_t        v;
        fd = $fopen("tb/thumb_ctrl_vectors.txt", "r");
        if (fd == 0) begin
            $display("could not open the vector file tb/thumb_ctrl_vectors.txt");
            load_failed = 1'b1;
        end else begin
            while (!$feof(fd)) begin
                line = "";
                void'($fgets(line, fd));
                fields = $sscanf(line, "%h %h %h %h %h %h %h %h %h %h %h %h %h",
                    f[0], f[1], f[2], f[3], f[4], f[5], f[6],
                    f[7], f[8], f[9], f[10], f[11], f[12]);
                // comment and blank lines fall through here
                if (fields == 13) begin
                    v.test      = f[0][7:0];
                    v.instr     = f[1][15:0];
                    v.dc        = f[2][15:0];
                    v.stall     = f[3][0];
                    v.valid     = f[4][0];
                    v.reg_write = f[5][0];
                    v.mem_write = f[6][0];
                    v.reg_addr  = f[7][3:0];
                    v.offset    = f[8];
                    v.alu_op    = f[9][3:0];
                    v.a_src     = f[10][1:0];
                    v.b_src     = f[11][1:0];
                    v.wb_src    = f[12][0];
                    vecs.push_back(v);
                end
            end
            $fclose(fd);
        end
    endtask

    task automatic check_field(input string name, input logic [31:0] exp_val,
                               input logic [31:0] act_val);
        assert (act_val === exp_val) else begin
            $display("** Error: %s expected 0x%h got 0x%h in test %0d",
                     name, exp_val, act_val, cur_test);
            test_errs++;
        end
    endtask

    task automatic apply_vector(input vec_t v);
        thumb_ctrl_pkg::instr_t drive_word;
        logic                   block_beat;
        rng_state  = xorshift32(rng_state);
        // register and immediate fields marked don't-care get random bits
        drive_word = (v.instr & ~v.dc) | (rng_state[15:0] & v.dc);
        // only sequenced beats take their offset from the controller
        block_beat = (v.b_src == thumb_ctrl_pkg::SRC_OFFSET);
        @(posedge clk);
        instr <= drive_word;
        #(CLK_PERIOD - 1);
        check_field("stall_o", 32'(v.stall), 32'(stall));
        check_field("ctrl_o.valid", 32'(v.valid), 32'(ctrl.valid));
        check_field("ctrl_o.reg_write", 32'(v.reg_write), 32'(ctrl.reg_write));
        check_field("ctrl_o.mem_write", 32'(v.mem_write), 32'(ctrl.mem_write));
        // a register loaded from memory needs a memory read
        check_field("ctrl_o.mem_read", 32'(v.reg_write & v.wb_src), 32'(ctrl.mem_read));
        // dropped opcodes only promise valid low and no writes
        if (v.valid) begin
            check_field("ctrl_o.reg_addr", 32'(v.reg_addr), 32'(ctrl.reg_addr));
            check_field("ctrl_o.offset_imm", v.offset, ctrl.offset_imm);
            check_field("ctrl_o.alu_op", 32'(v.alu_op), 32'(ctrl.alu_op));
            check_field("ctrl_o.alu_a_src", 32'(v.a_src), 32'(ctrl.alu_a_src));
            check_field("ctrl_o.alu_b_src", 32'(v.b_src), 32'(ctrl.alu_b_src));
            check_field("ctrl_o.wb_src", 32'(v.wb_src), 32'(ctrl.wb_src));
            // block beats name the written and stored registers from the controller
            if (v.reg_write) begin
                check_field("ctrl_o.dest_addr_src", 32'(block_beat),
                            32'(ctrl.dest_addr_src));
            end
            if (v.mem_write) begin
                check_field("ctrl_o.reg_addr2_src", 32'(block_beat),
                            32'(ctrl.reg_addr2_src));
            end
        end
    endtask

    task automatic finish_test();
        int cycles;
        cycles = 0;
        while (stall && cycles < STALL_LIMIT) begin
            @(posedge clk);
            #(CLK_PERIOD - 1);
            cycles++;
        end
        if (stall) begin
            $display("test %0d: stall never dropped within %0d cycles", cur_test, STALL_LIMIT);
            timed_out = 1'b1;
            test_errs++;
        end
        if (test_errs == 0) begin
            pass_count++;
            $display("test %0d: ok", cur_test);
        end else begin
            fail_count++;
            $display("test %0d: FAILED with %0d mismatches", cur_test, test_errs);
        end
        test_errs = 0;
    endtask

    initial begin
        clk         = 1'b0;
        rst         = 1'b1;
        instr       = '0;
        rng_state   = 32'h8d0a;
        cur_test    = '0;
        test_errs   = 0;
        pass_count  = 0;
        fail_count  = 0;
        timed_out   = 1'b0;
        load_failed = 1'b0;
        load_vectors();
        if (vecs.size() == 0 && !load_failed) begin
            $display("the vector file holds no vectors");
            load_failed = 1'b1;
        end
        repeat (5) @(posedge clk);
        rst <= 1'b0;
        if (!load_failed) begin
            cur_test = vecs[0].test;
            for (int i = 0; i < vecs.size() && !timed_out; i++) begin
                if (vecs[i].test != cur_test) begin
                    finish_test();
                    cur_test = vecs[i].test;
                end
                if (!timed_out) begin
                    apply_vector(vecs[i]);
                end
            end
            if (!timed_out) begin
                finish_test();
            end
        end
        $display("tests passed: %0d, tests failed: %0d", pass_count, fail_count);
        if (load_failed || timed_out || fail_count != 0) begin
            $display("Regression failed");
        end else begin
            $display("Regression passed");
        end
        $finish;
    end

endmodule

`default_nettype wire

// File: thumb_ctrl.f
logic/thumb_ctrl_pkg.sv
logic/reglist_scan.sv
logic/op_decoder.sv
logic/block_transfer_ctrl.sv
logic/thumb_ctrl_top.sv
tb/tb_thumb_ctrl.sv

// File: run_sim.sh
#!/bin/sh
set -e
cd "$(dirname "$0")"

verilator --binary --timing --assert -Wno-fatal --top-module tb_thumb_ctrl -f thumb_ctrl.f

./obj_dir/Vtb_thumb_ctrl > sim.log 2>&1
cat sim.log

grep -qx "Regression passed" sim.log

// File: tb/thumb_ctrl_vectors.txt
// test instr dont_care stall valid reg_write mem_write reg_addr offset alu_op a_src b_src wb_src
// alu_op 0 add 1 sub 2 and 3 or 4 xor 5 not 6 bic 7 mul 8 lsl 9 lsr a asr b ror
1 0000 07ff 0 1 1 0 0 0 8 0 1 0
1 1000 07ff 0 1 1 0 0 0 a 0 1 0
1 1a00 01ff 0 1 1 0 0 0 1 0 0 0
1 1c00 01ff 0 1 1 0 0 0 0 0 1 0
1 2000 07ff 0 1 1 0 0 0 0 2 1 0
1 2800 07ff 0 1 0 0 0 0 1 0 1 0
2 4000 003f 0 1 1 0 0 0 2 0 0 0
2 4040 003f 0 1 1 0 0 0 4 0 0 0
2 4080 003f 0 1 1 0 0 0 8 0 0 0
2 40c0 003f 0 1 1 0 0 0 9 0 0 0
2 4100 003f 0 1 1 0 0 0 a 0 0 0
2 4140 003f 0 1 1 0 0 0 0 0 0 0
2 4180 003f 0 1 1 0 0 0 1 0 0 0
2 41c0 003f 0 1 1 0 0 0 b 0 0 0
2 4200 003f 0 1 0 0 0 0 2 0 0 0
2 4240 003f 0 1 1 0 0 0 1 2 0 0
2 4280 003f 0 1 0 0 0 0 1 0 0 0
2 42c0 003f 0 1 0 0 0 0 0 0 0 0
2 4300 003f 0 1 1 0 0 0 3 0 0 0
2 4340 003f 0 1 1 0 0 0 7 0 0 0
2 4380 003f 0 1 1 0 0 0 6 0 0 0
2 43c0 003f 0 1 1 0 0 0 5 0 0 0
3 5000 01ff 0 1 0 1 0 0 0 0 0 1
3 5600 01ff 0 1 1 0 0 0 0 0 0 1
3 6800 07ff 0 1 1 0 0 0 0 0 1 1
3 7000 07ff 0 1 0 1 0 0 0 0 1 1
3 8800 07ff 0 1 1 0 0 0 0 0 1 1
3 9000 07ff 0 1 0 1 0 0 0 0 1 1
4 b512 0000 1 1 0 1 1 c 1 0 3 0
4 b512 0000 1 1 0 1 4 8 1 0 3 0
4 b512 0000 1 1 0 1 e 4 1 0 3 0
4 b512 0000 0 1 1 0 d c 1 0 3 0
4 bd05 0000 1 1 1 0 0 0 0 0 3 1
4 bd05 0000 1 1 1 0 2 4 0 0 3 1
4 bd05 0000 1 1 1 0 f 8 0 0 3 1
4 bd05 0000 0 1 1 0 d c 0 0 3 0
5 c22a 0000 1 1 0 1 1 0 0 0 3 0
5 c22a 0000 1 1 0 1 3 4 0 0 3 0
5 c22a 0000 1 1 0 1 5 8 0 0 3 0
5 c22a 0000 0 1 1 0 2 c 0 0 3 0
5 c945 0000 1 1 1 0 6 8 0 0 3 1
5 c945 0000 1 1 1 0 2 4 0 0 3 1
5 c945 0000 1 1 1 0 0 0 0 0 3 1
5 c945 0000 0 1 1 0 1 c 0 0 3 0
5 cb8a 0000 1 1 1 0 7 8 0 0 3 1
5 cb8a 0000 1 1 1 0 3 4 0 0 3 1
5 cb8a 0000 1 1 1 0 1 0 0 0 3 1
5 cb8a 0000 0 1 0 0 3 c 0 0 3 0
6 4400 03ff 0 0 0 0 0 0 0 0 0 0
6 b200 01ff 0 0 0 0 0 0 0 0 0 0
6 d000 07ff 0 0 0 0 0 0 0 0 0 0
